// File: control_unit.sv
`timescale 1ns/1ns

module control_unit
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  opcode_t opcode,
  input  logic    word_avail,
  input  logic    ex_busy,
  input  logic    taken,
  output logic    pop,
  output logic    issue,
  output logic    imm_sel,
  output logic    is_jump,
  output logic    redirect,
  output logic    halted
);

  dec_state_t state, state_nxt;
  logic       op_jump;

  assign op_jump = opcode inside {OP_JZ, OP_JN, OP_JC, OP_JMP};

  always_comb begin
    state_nxt = state;
    pop       = 1'b0;
    issue     = 1'b0;
    imm_sel   = 1'b0;
    case (state)
      DEC_IDLE: begin
        if (word_avail && !ex_busy) state_nxt = DEC_ISSUE;
      end
      DEC_ISSUE: begin
        pop = 1'b1;  // Head word is consumed here.
        if (opcode == OP_LDM) begin
          state_nxt = DEC_IMM;
        end else if (opcode == OP_HLT) begin
          state_nxt = DEC_HALT;
        end else if (op_jump) begin
          state_nxt = DEC_IDLE;
        end else begin
          issue     = 1'b1;
          state_nxt = DEC_WAIT;
        end
      end
      DEC_IMM: begin
        if (word_avail) begin
          pop       = 1'b1;
          issue     = 1'b1;
          imm_sel   = 1'b1;
          state_nxt = DEC_WAIT;
        end
      end
      DEC_WAIT: begin
        if (!ex_busy) state_nxt = DEC_IDLE;  // Wait for retire.
      end
      DEC_HALT: state_nxt = DEC_HALT;
      default:  state_nxt = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= DEC_IDLE;
    else state <= state_nxt;
  end

  assign is_jump  = (state == DEC_ISSUE) && op_jump;
  assign redirect = is_jump && taken;
  assign halted   = (state == DEC_HALT);

  a_pop_avail: assert property (@(posedge clk) disable iff (rst) pop |-> word_avail);

endmodule

// File: cpu_pkg.sv
`include "mini_cpu_defs.svh"

package cpu_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`OPC_W-1:0]  opcode_t;
  typedef logic [2:0]         flags_t;  // {carry, negative, zero}.

  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_C = 2;

  localparam opcode_t OP_NOP = 5'd0;
  localparam opcode_t OP_ADD = 5'd1;
  localparam opcode_t OP_SUB = 5'd2;
  localparam opcode_t OP_AND = 5'd3;
  localparam opcode_t OP_OR  = 5'd4;
  localparam opcode_t OP_NOT = 5'd5;
  localparam opcode_t OP_SHL = 5'd6;
  localparam opcode_t OP_LDM = 5'd7;
  localparam opcode_t OP_LDD = 5'd8;
  localparam opcode_t OP_STD = 5'd9;
  localparam opcode_t OP_OUT = 5'd10;
  localparam opcode_t OP_JZ  = 5'd11;
  localparam opcode_t OP_JN  = 5'd12;
  localparam opcode_t OP_JC  = 5'd13;
  localparam opcode_t OP_JMP = 5'd14;
  localparam opcode_t OP_HLT = 5'd15;

  typedef enum logic [2:0] {DEC_IDLE, DEC_ISSUE, DEC_IMM, DEC_WAIT, DEC_HALT} dec_state_t;
  typedef enum logic [1:0] {EX_IDLE, EX_MEM, EX_DONE} ex_state_t;

endpackage

// File: execute_unit.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module execute_unit
  import cpu_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,
  input  opcode_t             op,
  input  reg_addr_t           ra,
  input  word_t               a,
  input  word_t               b,
  input  word_t               imm,
  input  logic [`SHAMT_W-1:0] shamt,
  output logic                busy,
  output flags_t              flags,
  output logic                wb_en,
  output reg_addr_t           wb_addr,
  output word_t               wb_data,
  output logic                mem_req,
  output logic                mem_we,
  output addr_t               mem_addr,
  output word_t               mem_wdata,
  input  logic                mem_gnt,
  input  logic                mem_rvalid,
  input  word_t               mem_rdata,
  output logic                out_valid,
  output word_t               out_data
);

  ex_state_t        state;
  logic [`WORD_W:0] alu_full;  // Carry in the top bit.
  logic             is_alu;
  logic             rd_wait;
  logic             start;

  // ======================================
  // ALU.
  // ======================================
  always_comb begin
    case (op)
      OP_ADD:  alu_full = {1'b0, a} + {1'b0, b};
      OP_SUB:  alu_full = {1'b0, a} - {1'b0, b};  // Borrow out.
      OP_AND:  alu_full = {1'b0, a & b};
      OP_OR:   alu_full = {1'b0, a | b};
      OP_NOT:  alu_full = {1'b0, ~a};
      OP_SHL:  alu_full = {1'b0, a} << shamt;
      OP_LDM:  alu_full = {1'b0, imm};
      default: alu_full = {1'b0, a};
    endcase
  end

  assign is_alu  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL};
  assign start   = issue && (state == EX_IDLE);
  assign busy    = issue || (state != EX_IDLE);
  assign mem_req = (state == EX_MEM) && !rd_wait;

  // ======================================
  // Control.
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= EX_IDLE;
      flags     <= '0;
      wb_en     <= 1'b0;
      out_valid <= 1'b0;
      rd_wait   <= 1'b0;
    end else begin
      wb_en     <= 1'b0;
      out_valid <= 1'b0;
      case (state)
        EX_IDLE: begin
          if (issue) begin
            state     <= (op == OP_LDD || op == OP_STD) ? EX_MEM : EX_DONE;
            wb_en     <= is_alu || (op == OP_LDM);
            out_valid <= (op == OP_OUT);
            if (is_alu) begin
              flags[FLAG_Z] <= (alu_full[`WORD_W-1:0] == '0);
              flags[FLAG_N] <= alu_full[`WORD_W-1];
              if (op inside {OP_ADD, OP_SUB, OP_SHL}) flags[FLAG_C] <= alu_full[`WORD_W];
            end
          end
        end
        EX_MEM: begin
          if (mem_gnt) begin
            if (mem_we) state <= EX_DONE;  // Store done at grant.
            else rd_wait <= 1'b1;
          end else if (mem_rvalid && rd_wait) begin
            rd_wait <= 1'b0;
            wb_en   <= 1'b1;
            state   <= EX_DONE;
          end
        end
        EX_DONE: state <= EX_IDLE;
        default: state <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wb_addr   <= ra;
      wb_data   <= alu_full[`WORD_W-1:0];
      out_data  <= a;
      mem_we    <= (op == OP_STD);
      mem_addr  <= b[`ADDR_W-1:0];
      mem_wdata <= a;
    end else if (mem_rvalid && rd_wait) begin
      wb_data <= mem_rdata;
    end
  end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module fetch_unit
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_gnt,
  input  logic  mem_rvalid,
  input  word_t mem_rdata,
  output logic  iq_valid,
  output word_t iq_word,
  input  logic  credit_ret,
  input  logic  redirect,
  input  addr_t redirect_pc,
  input  logic  halted
);

  localparam int CNT_W = $clog2(`IQ_DEPTH) + 1;

  addr_t            pc;
  logic [CNT_W-1:0] credits;
  logic             drop_pending;  // Stale response still in flight.

  assign mem_req  = (credits != '0) && !halted;
  assign mem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      credits      <= CNT_W'(`IQ_DEPTH);
      drop_pending <= 1'b0;
      iq_valid     <= 1'b0;
    end else begin
      iq_valid <= mem_rvalid && !drop_pending && !redirect;
      if (redirect) begin
        pc           <= redirect_pc;
        credits      <= CNT_W'(`IQ_DEPTH);
        drop_pending <= mem_gnt;
      end else begin
        if (mem_gnt) pc <= pc + 1'b1;
        credits <= credits - CNT_W'(mem_gnt) + CNT_W'(credit_ret);
        if (mem_rvalid) drop_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rvalid) iq_word <= mem_rdata;
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= CNT_W'(`IQ_DEPTH));

endmodule

// File: instr_decode.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module instr_decode
  import cpu_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                iq_valid,
  input  word_t               iq_word,
  output logic                credit_ret,
  output logic                redirect,
  output addr_t               redirect_pc,
  input  logic                ex_busy,
  input  flags_t              flags,
  input  logic                wb_en,
  input  reg_addr_t           wb_addr,
  input  word_t               wb_data,
  output logic                ex_issue,
  output opcode_t             ex_op,
  output reg_addr_t           ex_ra,
  output word_t               ex_a,
  output word_t               ex_b,
  output word_t               ex_imm,
  output logic [`SHAMT_W-1:0] ex_shamt,
  output logic                halted
);

  localparam int PTR_W = $clog2(`IQ_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  word_t            iq_mem [`IQ_DEPTH];
  logic [PTR_W-1:0] head, tail;
  logic [CNT_W-1:0] count;
  word_t            head_word;
  opcode_t          opcode;
  reg_addr_t        ra, rb;
  word_t            rd_data1, rd_data2;
  logic             pop, issue, imm_sel, is_jump, taken;

  // ======================================
  // Instruction queue.
  // ======================================
  always_ff @(posedge clk) begin
    if (iq_valid) iq_mem[tail] <= iq_word;
  end

  always_ff @(posedge clk) begin
    if (rst || redirect) begin  // Flush on taken jump.
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (iq_valid) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      count <= count + CNT_W'(iq_valid) - CNT_W'(pop);
    end
  end

  assign head_word  = iq_mem[head];
  assign credit_ret = pop;

  // Field split.
  assign opcode = head_word[`WORD_W-1 -: `OPC_W];
  assign ra     = head_word[10:8];
  assign rb     = head_word[7:5];

  reg_file reg_file_inst (
    .clk (clk), .rst (rst),
    .rd_addr1 (ra), .rd_addr2 (rb),
    .rd_data1 (rd_data1), .rd_data2 (rd_data2),
    .wr_en (wb_en), .wr_addr (wb_addr), .wr_data (wb_data)
  );

  control_unit control_unit_inst (
    .clk (clk), .rst (rst),
    .opcode (opcode), .word_avail (count != '0), .ex_busy (ex_busy), .taken (taken),
    .pop (pop), .issue (issue), .imm_sel (imm_sel), .is_jump (is_jump),
    .redirect (redirect), .halted (halted)
  );

  jump_unit jump_unit_inst (
    .opcode (opcode), .flags (flags), .target (rd_data2),
    .taken (taken), .redirect_pc (redirect_pc)
  );

  // ======================================
  // Issue registers toward execute.
  // ======================================
  always_ff @(posedge clk) begin
    if (pop && !imm_sel && !is_jump) begin
      ex_op    <= opcode;
      ex_ra    <= ra;
      ex_a     <= rd_data1;
      ex_b     <= rd_data2;
      ex_shamt <= head_word[`SHAMT_W-1:0];
    end
    if (imm_sel) ex_imm <= head_word;  // Second word of LDM.
  end

  always_ff @(posedge clk) begin
    if (rst) ex_issue <= 1'b0;
    else ex_issue <= issue;
  end

endmodule

// File: jump_unit.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module jump_unit
  import cpu_pkg::*;
(
  input  opcode_t opcode,
  input  flags_t  flags,
  input  word_t   target,
  output logic    taken,
  output addr_t   redirect_pc
);

  always_comb begin
    case (opcode)
      OP_JMP:  taken = 1'b1;
      OP_JZ:   taken = flags[FLAG_Z];
      OP_JN:   taken = flags[FLAG_N];
      OP_JC:   taken = flags[FLAG_C];
      default: taken = 1'b0;
    endcase
  end

  assign redirect_pc = target[`ADDR_W-1:0];  // Low bits of rb.

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  host_req,
  input  logic  host_we,
  input  addr_t host_addr,
  input  word_t host_wdata,
  output logic  host_gnt,
  output logic  host_rvalid,
  input  logic  data_req,
  input  logic  data_we,
  input  addr_t data_addr,
  input  word_t data_wdata,
  output logic  data_gnt,
  output logic  data_rvalid,
  input  logic  fetch_req,
  input  addr_t fetch_addr,
  output logic  fetch_gnt,
  output logic  fetch_rvalid,
  output logic  mem_en,
  output logic  mem_we,
  output addr_t mem_addr,
  output word_t mem_wdata
);

  logic [2:0] rd_owner;  // {fetch, data, host}.

  // Host first, then data, then fetch.
  assign host_gnt  = host_req;
  assign data_gnt  = data_req && !host_req;
  assign fetch_gnt = fetch_req && !host_req && !data_req;

  assign mem_en    = host_req || data_req || fetch_req;
  assign mem_we    = host_gnt ? host_we : (data_gnt && data_we);
  assign mem_addr  = host_gnt ? host_addr : (data_gnt ? data_addr : fetch_addr);
  assign mem_wdata = host_gnt ? host_wdata : data_wdata;

  always_ff @(posedge clk) begin
    if (rst) rd_owner <= '0;
    else rd_owner <= {fetch_gnt, data_gnt && !data_we, host_gnt && !host_we};
  end

  assign host_rvalid  = rd_owner[0];
  assign data_rvalid  = rd_owner[1];
  assign fetch_rvalid = rd_owner[2];

endmodule

// File: mini_cpu.f
+incdir+.
cpu_pkg.sv
reg_file.sv
jump_unit.sv
control_unit.sv
instr_decode.sv
fetch_unit.sv
mem_arbiter.sv
unified_mem.sv
execute_unit.sv
mini_cpu_top.sv
mini_cpu_tb.sv

// File: mini_cpu_defs.svh
`ifndef MINI_CPU_DEFS_SVH
`define MINI_CPU_DEFS_SVH

// Datapath and memory widths.
`define WORD_W    16
`define ADDR_W    8
`define MEM_DEPTH 256

// Instruction fields.
`define REG_AW    3
`define OPC_W     5
`define SHAMT_W   4

// Decode queue depth, also the fetch credit count.
`define IQ_DEPTH  4

`endif

// File: mini_cpu_tb.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module mini_cpu_tb
  import cpu_pkg::*;
();

  localparam int DATA_BASE  = 'hE0;
  localparam int DATA_WORDS = 16;

  logic      clk, rst;
  logic      host_req, host_we;
  addr_t     host_addr;
  word_t     host_wdata, host_rdata;
  logic      host_gnt, host_rvalid;
  logic      wb_valid, out_valid, halted;
  reg_addr_t wb_addr;
  word_t     wb_data, out_data;

  int        seed;
  int        cycles = 0;
  int        cycle_limit = 0;
  logic      halt_seen;
  word_t     prog [$];
  reg_addr_t exp_wb_addr [$];
  word_t     exp_wb_data [$];
  word_t     exp_out [$];
  word_t     ref_mem [`MEM_DEPTH];
  opcode_t   alu_ops [6]  = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL};
  opcode_t   jump_ops [4] = '{OP_JZ, OP_JN, OP_JC, OP_JMP};

  mini_cpu_top UUT (
    .clk (clk), .rst (rst),
    .host_req (host_req), .host_we (host_we), .host_addr (host_addr),
    .host_wdata (host_wdata), .host_gnt (host_gnt), .host_rvalid (host_rvalid),
    .host_rdata (host_rdata),
    .wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
    .out_valid (out_valid), .out_data (out_data), .halted (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_with_error();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      stop_with_error();
    end
  endtask

  // ======================================
  // Program construction.
  // ======================================
  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(1 + rand_below(5));  // r1 to r5.
  endfunction

  function automatic void emit(opcode_t op, reg_addr_t ra, reg_addr_t rb, logic [3:0] sh);
    prog.push_back({op, ra, rb, 1'b0, sh});
  endfunction

  // Index of the immediate word, for patching jump targets.
  function automatic int emit_ldm(reg_addr_t ra, word_t value);
    emit(OP_LDM, ra, 3'd0, 4'd0);
    prog.push_back(value);
    return prog.size() - 1;
  endfunction

  function automatic void emit_rand_alu();
    emit(alu_ops[rand_below(6)], rand_reg(), reg_addr_t'(rand_below(6)), 4'(rand_below(16)));
  endfunction

  // Target in r7, flag setter, jump, one shadow word.
  function automatic void emit_jump_block(opcode_t jop, opcode_t aop, reg_addr_t x, reg_addr_t y);
    int fix;
    fix = emit_ldm(3'd7, '0);
    emit(aop, x, y, 4'd1);
    emit(jop, 3'd0, 3'd7, 4'd0);
    emit(OP_ADD, 3'd1, 3'd2, 4'd0);
    prog[fix] = word_t'(prog.size());
  endfunction

  function automatic void build_program();
    for (int r = 1; r <= 6; r++) begin
      void'(emit_ldm(reg_addr_t'(r), word_t'($random(seed))));
    end
    for (int i = 0; i < 12; i++) begin
      emit(alu_ops[i % 6], rand_reg(), reg_addr_t'(rand_below(6)), 4'(rand_below(16)));
    end
    emit(OP_NOP, 3'd0, 3'd0, 4'd0);
    // Known flag outcomes first, then random ones.
    void'(emit_ldm(3'd4, 16'h0001));
    void'(emit_ldm(3'd5, 16'hFFFF));
    emit_jump_block(OP_JC, OP_ADD, 3'd5, 3'd4);
    emit_jump_block(OP_JZ, OP_ADD, 3'd4, 3'd4);
    emit_jump_block(OP_JN, OP_NOT, 3'd4, 3'd0);
    emit_jump_block(OP_JZ, OP_SUB, 3'd3, 3'd3);
    emit_jump_block(OP_JMP, OP_OR, 3'd1, 3'd2);
    for (int i = 0; i < 6; i++) begin
      emit_jump_block(jump_ops[rand_below(4)], alu_ops[rand_below(6)], rand_reg(),
                      reg_addr_t'(rand_below(6)));
    end
    // Stores mixed into a dense ALU run.
    for (int i = 0; i < DATA_WORDS; i++) begin
      void'(emit_ldm(3'd6, word_t'(DATA_BASE + i)));
      emit_rand_alu();
      emit(OP_STD, rand_reg(), 3'd6, 4'd0);
      emit_rand_alu();
      if (i % 4 == 0) emit(OP_OUT, rand_reg(), 3'd0, 4'd0);
    end
    for (int k = 0; k < 4; k++) begin
      void'(emit_ldm(3'd6, word_t'(DATA_BASE + 8 + k)));
      emit(OP_STD, reg_addr_t'(k + 1), 3'd6, 4'd0);
      emit(OP_LDD, 3'd5, 3'd6, 4'd0);  // Read back.
    end
    for (int r = 1; r <= 5; r++) emit(OP_OUT, reg_addr_t'(r), 3'd0, 4'd0);
    emit(OP_HLT, 3'd0, 3'd0, 4'd0);
    emit(OP_OUT, 3'd1, 3'd0, 4'd0);  // Past the halt.
    emit(OP_ADD, 3'd1, 3'd2, 4'd0);
  endfunction

  // ======================================
  // Instruction-set model.
  // ======================================
  function automatic void run_reference();
    word_t      regs [8];
    logic       fz, fn, fc;
    int         pc;
    word_t      w, a, b, res;
    opcode_t    op;
    reg_addr_t  ra;
    logic [3:0] sh;
    for (int i = 0; i < 8; i++) regs[i] = '0;
    {fz, fn, fc} = 3'b000;
    pc = 0;
    res = '0;
    for (int step = 0; step < 4 * prog.size(); step++) begin
      w  = prog[pc];
      pc = pc + 1;
      op = w[15:11];
      ra = w[10:8];
      a  = regs[ra];
      b  = regs[w[7:5]];
      sh = w[3:0];
      case (op)
        OP_ADD: begin
          res = a + b;
          fc  = (32'(a) + 32'(b)) > 32'hFFFF;
        end
        OP_SUB: begin
          res = a - b;
          fc  = (a < b);  // Borrow.
        end
        OP_AND: res = a & b;
        OP_OR:  res = a | b;
        OP_NOT: res = ~a;
        OP_SHL: begin
          res = a << sh;
          fc  = (sh != 0) && a[16 - sh];  // Last bit shifted out.
        end
        OP_LDM: begin
          res = prog[pc];
          pc  = pc + 1;
        end
        OP_LDD: res = ref_mem[b[`ADDR_W-1:0]];
        OP_STD: ref_mem[b[`ADDR_W-1:0]] = a;
        OP_OUT: exp_out.push_back(a);
        OP_JZ:  if (fz) pc = b[`ADDR_W-1:0];
        OP_JN:  if (fn) pc = b[`ADDR_W-1:0];
        OP_JC:  if (fc) pc = b[`ADDR_W-1:0];
        OP_JMP: pc = b[`ADDR_W-1:0];
        OP_HLT: return;
        default: ;
      endcase
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL}) begin
        fz = (res == '0);
        fn = res[15];
      end
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL, OP_LDM, OP_LDD}) begin
        regs[ra] = res;
        exp_wb_addr.push_back(ra);
        exp_wb_data.push_back(res);
      end
    end
  endfunction

  // ======================================
  // Host port.
  // ======================================
  task automatic wait_host_grant();
    do @(posedge clk); while (!host_gnt);
    #1;
  endtask

  task automatic host_write(addr_t addr, word_t data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    wait_host_grant();
    host_req   = 1'b0;
    host_we    = 1'b0;
  endtask

  // Read data arrives one cycle after the grant.
  task automatic host_read(addr_t addr, output word_t data);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    wait_host_grant();
    host_req  = 1'b0;
    if (!host_rvalid) begin
      $display("ERROR at %0t ns: no host read response for address %h", $time, addr);
      stop_with_error();
    end
    data = host_rdata;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("ERROR: timeout before halt after %0d cycles", cycles);
      stop_with_error();
    end
  end

  // Retirement checks, mid-cycle.
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_valid) begin
        if (halt_seen || exp_wb_addr.size() == 0) begin
          $display("ERROR at %0t ns: unexpected write-back to r%0d", $time, wb_addr);
          stop_with_error();
        end else begin
          check_value("wb_addr", exp_wb_addr.pop_front(), wb_addr);
          check_value("wb_data", exp_wb_data.pop_front(), wb_data);
        end
      end
      if (out_valid) begin
        if (halt_seen || exp_out.size() == 0) begin
          $display("ERROR at %0t ns: unexpected output value %h", $time, out_data);
          stop_with_error();
        end else begin
          check_value("out_data", exp_out.pop_front(), out_data);
        end
      end
      if (halt_seen && !halted) begin
        $display("ERROR at %0t ns: halted dropped before the end of the run", $time);
        stop_with_error();
      end
      if (halted) halt_seen = 1'b1;
    end
  end

  initial begin
    word_t rdata;
    seed       = 89;
    rst        = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    halt_seen  = 1'b0;
    build_program();
    run_reference();
    cycle_limit = 40 * prog.size() + 200;

    // Reset for 10 cycles, held on through the program load.
    repeat (10) @(posedge clk);
    #1;
    for (int i = 0; i < prog.size(); i++) host_write(addr_t'(i), prog[i]);
    @(posedge clk);
    #1;
    rst = 1'b0;

    while (!halt_seen) begin
      @(posedge clk);
      #1;
    end
    repeat (20) @(posedge clk);  // Stray retirements show here.
    #1;
    for (int i = 0; i < DATA_WORDS; i++) begin
      host_read(addr_t'(DATA_BASE + i), rdata);
      check_value("host_rdata", ref_mem[DATA_BASE + i], rdata);
    end

    if (exp_wb_addr.size() != 0 || exp_out.size() != 0) begin
      $display("ERROR: %0d write-backs and %0d outputs never retired",
               exp_wb_addr.size(), exp_out.size());
      stop_with_error();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: mini_cpu_top.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module mini_cpu_top
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      host_req,
  input  logic      host_we,
  input  addr_t     host_addr,
  input  word_t     host_wdata,
  output logic      host_gnt,
  output logic      host_rvalid,
  output word_t     host_rdata,
  output logic      wb_valid,
  output reg_addr_t wb_addr,
  output word_t     wb_data,
  output logic      out_valid,
  output word_t     out_data,
  output logic      halted
);

  // Fetch and decode.
  logic      f_req, f_gnt, f_rvalid, iq_valid, credit_ret, redirect;
  addr_t     f_addr, redirect_pc;
  word_t     iq_word;
  // Decode to execute.
  logic      ex_issue, ex_busy;
  opcode_t   ex_op;
  reg_addr_t ex_ra;
  word_t     ex_a, ex_b, ex_imm;
  logic [`SHAMT_W-1:0] ex_shamt;
  flags_t    flags;
  // Data port and memory.
  logic      d_req, d_we, d_gnt, d_rvalid, mem_en, mem_we;
  addr_t     d_addr, mem_addr;
  word_t     d_wdata, mem_wdata, mem_rdata;

  assign host_rdata = mem_rdata;  // Read data to every requester.

  // ======================================
  // Core.
  // ======================================
  fetch_unit fetch_unit_inst (
    .clk (clk), .rst (rst),
    .mem_req (f_req), .mem_addr (f_addr), .mem_gnt (f_gnt),
    .mem_rvalid (f_rvalid), .mem_rdata (mem_rdata),
    .iq_valid (iq_valid), .iq_word (iq_word), .credit_ret (credit_ret),
    .redirect (redirect), .redirect_pc (redirect_pc), .halted (halted)
  );

  instr_decode instr_decode_inst (
    .clk (clk), .rst (rst),
    .iq_valid (iq_valid), .iq_word (iq_word), .credit_ret (credit_ret),
    .redirect (redirect), .redirect_pc (redirect_pc),
    .ex_busy (ex_busy), .flags (flags),
    .wb_en (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
    .ex_issue (ex_issue), .ex_op (ex_op), .ex_ra (ex_ra),
    .ex_a (ex_a), .ex_b (ex_b), .ex_imm (ex_imm), .ex_shamt (ex_shamt),
    .halted (halted)
  );

  execute_unit execute_unit_inst (
    .clk (clk), .rst (rst),
    .issue (ex_issue), .op (ex_op), .ra (ex_ra),
    .a (ex_a), .b (ex_b), .imm (ex_imm), .shamt (ex_shamt),
    .busy (ex_busy), .flags (flags),
    .wb_en (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
    .mem_req (d_req), .mem_we (d_we), .mem_addr (d_addr), .mem_wdata (d_wdata),
    .mem_gnt (d_gnt), .mem_rvalid (d_rvalid), .mem_rdata (mem_rdata),
    .out_valid (out_valid), .out_data (out_data)
  );

  // ======================================
  // Shared memory.
  // ======================================
  mem_arbiter mem_arbiter_inst (
    .clk (clk), .rst (rst),
    .host_req (host_req), .host_we (host_we), .host_addr (host_addr),
    .host_wdata (host_wdata), .host_gnt (host_gnt), .host_rvalid (host_rvalid),
    .data_req (d_req), .data_we (d_we), .data_addr (d_addr),
    .data_wdata (d_wdata), .data_gnt (d_gnt), .data_rvalid (d_rvalid),
    .fetch_req (f_req), .fetch_addr (f_addr),
    .fetch_gnt (f_gnt), .fetch_rvalid (f_rvalid),
    .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata)
  );

  unified_mem unified_mem_inst (
    .clk (clk), .en (mem_en), .we (mem_we),
    .addr (mem_addr), .wdata (mem_wdata), .rdata (mem_rdata)
  );

endmodule

// File: reg_file.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module reg_file
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rd_addr1,
  input  reg_addr_t rd_addr2,
  output word_t     rd_data1,
  output word_t     rd_data2,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [2**`REG_AW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data1 = regs[rd_addr1];  // No write bypass.
  assign rd_data2 = regs[rd_addr2];

endmodule

// File: unified_mem.sv
`timescale 1ns/1ns
`include "mini_cpu_defs.svh"

module unified_mem
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  output word_t rdata
);

  word_t mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) mem[addr] <= wdata;
      else rdata <= mem[addr];  // One cycle read.
    end
  end

endmodule
